/* design/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic                  clk,
    input  logic                  rstn,
    input  mem_bus_pkg::mem_req_t mem_req,
    output mem_bus_pkg::mem_rsp_t mem_rsp
);
    import mem_bus_pkg::*;

    typedef enum logic {
        RAM_IDLE = 1'b0,
        RAM_BUSY = 1'b1
    } ram_state_e;

    ram_state_e                state;
    logic [LAT_CNT_W-1:0]      lat_cnt;
    logic                      data_ok_q;
    logic [MEM_DATA_W-1:0]     rdata_q;
    logic [RAM_DEPTH_LOG2-1:0] raddr_q;
    logic [RAM_DEPTH_LOG2-1:0] word_idx;
    logic                      accept;

    logic [MEM_DATA_W-1:0]     mem [RAM_DEPTH];

    // contents start at zero
    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // upper address bits ignored
    assign word_idx = mem_req.addr[RAM_DEPTH_LOG2+1:2];
    assign accept   = mem_req.req && (state == RAM_IDLE);

    //////////////////////////////////////////////////
    // read latency sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= RAM_IDLE;
            lat_cnt   <= '0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= 1'b0;
            case (state)
                RAM_IDLE: begin
                    if (accept && !mem_req.wr) begin
                        state   <= RAM_BUSY;
                        lat_cnt <= LAT_CNT_W'(RAM_READ_LAT - 1);
                    end
                end
                default: begin
                    // last count raises data_ok for one cycle
                    if (lat_cnt == '0) begin
                        state     <= RAM_IDLE;
                        data_ok_q <= 1'b1;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // array access
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            raddr_q <= word_idx;
        end
        // byte write enables from wstrb
        if (accept && mem_req.wr) begin
            for (int b = 0; b < MEM_STRB_W; b++) begin
                if (mem_req.wstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                end
            end
        end
        if (state == RAM_BUSY && lat_cnt == '0) begin
            rdata_q <= mem[raddr_q];
        end
    end

    // addr_ok held off while a read is outstanding
    assign mem_rsp.addr_ok = accept;
    assign mem_rsp.data_ok = data_ok_q;
    assign mem_rsp.rdata   = rdata_q;

endmodule

/* design/dcache_bypass.sv */
`timescale 1ns/1ps

module dcache_bypass (
    input  logic                  clk,
    input  logic                  rstn,
    input  lsu_pkg::word_req_t    word_req,
    output logic                  ready,
    output logic [31:0]           rdata,
    output mem_bus_pkg::mem_req_t mem_req,
    input  mem_bus_pkg::mem_rsp_t mem_rsp
);
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        BYP_IDLE = 2'd0,
        BYP_REQ  = 2'd1,
        BYP_WAIT = 2'd2,
        BYP_DONE = 2'd3
    } byp_state_e;

    byp_state_e            state;
    byp_state_e            next_state;
    // word captured at data_ok
    logic [MEM_DATA_W-1:0] rdata_q;

    //////////////////////////////////////////////////
    // state sequence
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= BYP_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            BYP_IDLE: begin
                // request goes out from idle, may be taken at once
                if (word_req.valid) begin
                    if (!mem_rsp.addr_ok) begin
                        next_state = BYP_REQ;
                    end else if (!word_req.wr) begin
                        next_state = BYP_WAIT;
                    end
                end
            end
            BYP_REQ: begin
                if (mem_rsp.addr_ok) begin
                    next_state = word_req.wr ? BYP_IDLE : BYP_WAIT;
                end
            end
            BYP_WAIT: begin
                if (mem_rsp.data_ok) begin
                    next_state = BYP_DONE;
                end
            end
            default: next_state = BYP_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // handshake outputs
    //////////////////////////////////////////////////

    always_comb begin
        ready = 1'b0;
        case (state)
            BYP_IDLE: begin
                if (word_req.valid) begin
                    // write done on accept
                    ready = mem_rsp.addr_ok && word_req.wr;
                end else begin
                    ready = 1'b1;
                end
            end
            BYP_REQ: begin
                ready = mem_rsp.addr_ok && word_req.wr;
            end
            BYP_DONE: ready = 1'b1;
            default: ;
        endcase
    end

    // req from the idle cycle of a valid request until addr_ok
    assign mem_req.req   = (state == BYP_REQ) || (state == BYP_IDLE && word_req.valid);

    // whole words only, strobes pick the bytes
    assign mem_req.wr    = word_req.wr;
    assign mem_req.addr  = word_req.addr;
    assign mem_req.wdata = word_req.wdata;
    assign mem_req.wstrb = word_req.wstrb;

    // ram need not hold rdata past data_ok
    always_ff @(posedge clk) begin
        if (state == BYP_WAIT && mem_rsp.data_ok) begin
            rdata_q <= mem_rsp.rdata;
        end
    end

    assign rdata = rdata_q;

endmodule

/* design/lsu_align.sv */
`timescale 1ns/1ps

module lsu_align (
    input  lsu_pkg::lsu_req_t  core_req,
    output lsu_pkg::word_req_t word_req,
    input  logic               word_ready,
    input  logic [31:0]        word_rdata,
    output logic               ready,
    output logic [31:0]        rdata,
    output logic               misalign
);
    import lsu_pkg::*;

    // access width and direction
    logic                  is_byte;
    logic                  is_half;
    logic                  is_word;
    logic                  is_store;
    logic                  bad_align;
    // load lanes picked from the returned word
    logic [7:0]            ld_byte;
    logic [15:0]           ld_half;
    logic [LSU_STRB_W-1:0] strb;
    logic [LSU_DATA_W-1:0] lane_wdata;

    //////////////////////////////////////////////////
    // opcode decode
    //////////////////////////////////////////////////

    always_comb begin
        is_byte  = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        is_store = 1'b0;
        case (core_req.op)
            OP_LB, OP_LBU: is_byte = 1'b1;
            OP_LH, OP_LHU: is_half = 1'b1;
            OP_LW:         is_word = 1'b1;
            OP_SB: begin
                is_byte  = 1'b1;
                is_store = 1'b1;
            end
            OP_SH: begin
                is_half  = 1'b1;
                is_store = 1'b1;
            end
            default: begin
                is_word  = 1'b1;
                is_store = 1'b1;
            end
        endcase
    end

    // halfword on odd byte, word off a 4-byte boundary
    assign bad_align = (is_half && core_req.addr[0]) ||
                       (is_word && (core_req.addr[1:0] != 2'b00));

    //////////////////////////////////////////////////
    // strobes and store lanes
    //////////////////////////////////////////////////

    always_comb begin
        if (is_byte) begin
            strb       = LSU_STRB_W'(1) << core_req.addr[1:0];
            lane_wdata = {4{core_req.wdata[7:0]}};
        end else if (is_half) begin
            strb       = core_req.addr[1] ? 4'b1100 : 4'b0011;
            lane_wdata = {2{core_req.wdata[15:0]}};
        end else begin
            strb       = 4'b1111;
            lane_wdata = core_req.wdata;
        end
    end

    // misaligned requests never reach the controller
    assign word_req.valid = core_req.valid && !bad_align;
    assign word_req.wr    = is_store;
    assign word_req.addr  = {core_req.addr[LSU_ADDR_W-1:2], 2'b00};
    assign word_req.wdata = lane_wdata;
    assign word_req.wstrb = strb;

    //////////////////////////////////////////////////
    // load extraction
    //////////////////////////////////////////////////

    assign ld_byte = word_rdata[8*core_req.addr[1:0] +: 8];
    assign ld_half = core_req.addr[1] ? word_rdata[31:16] : word_rdata[15:0];

    always_comb begin
        case (core_req.op)
            OP_LB:   rdata = {{24{ld_byte[7]}}, ld_byte};
            OP_LBU:  rdata = {24'd0, ld_byte};
            OP_LH:   rdata = {{16{ld_half[15]}}, ld_half};
            OP_LHU:  rdata = {16'd0, ld_half};
            // stores leave rdata as don't-care
            default: rdata = word_rdata;
        endcase
    end

    // rejected in the same cycle
    assign misalign = core_req.valid && bad_align;
    assign ready    = misalign || word_ready;

endmodule

/* design/lsu_mem_top.sv */
`timescale 1ns/1ps

module lsu_mem_top (
    input  logic              clk,
    input  logic              rstn,
    input  lsu_pkg::lsu_req_t lsu_req,
    output logic              ready,
    output logic [31:0]       rdata,
    output logic              misalign
);
    import lsu_pkg::*;
    import mem_bus_pkg::*;

    // align stage to controller
    word_req_t             word_req;
    logic                  word_ready;
    logic [MEM_DATA_W-1:0] word_rdata;
    // controller to ram
    mem_req_t              mem_req;
    mem_rsp_t              mem_rsp;

    //////////////////////////////////////////////////
    // core side alignment
    //////////////////////////////////////////////////

    lsu_align u_lsu_align (
        .core_req   (lsu_req),
        .word_req   (word_req),
        .word_ready (word_ready),
        .word_rdata (word_rdata),
        .ready      (ready),
        .rdata      (rdata),
        .misalign   (misalign)
    );

    //////////////////////////////////////////////////
    // uncached controller and ram
    //////////////////////////////////////////////////

    dcache_bypass u_dcache_bypass (
        .clk      (clk),
        .rstn     (rstn),
        .word_req (word_req),
        .ready    (word_ready),
        .rdata    (word_rdata),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .rstn    (rstn),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

/* design/lsu_pkg.sv */
package lsu_pkg;

    //////////////////////////////////////////////////
    // core side sizes
    //////////////////////////////////////////////////

    localparam int LSU_ADDR_W = 32;
    localparam int LSU_DATA_W = 32;
    localparam int LSU_STRB_W = LSU_DATA_W / 8;

    // loads first, stores after
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LBU = 3'd1,
        OP_LH  = 3'd2,
        OP_LHU = 3'd3,
        OP_LW  = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } lsu_op_e;

    //////////////////////////////////////////////////
    // request bundles
    //////////////////////////////////////////////////

    // held stable by the core until ready
    typedef struct packed {
        logic                  valid;
        lsu_op_e               op;
        logic [LSU_ADDR_W-1:0] addr;
        logic [LSU_DATA_W-1:0] wdata;
    } lsu_req_t;

    // word access after alignment
    typedef struct packed {
        logic                  valid;
        logic                  wr;
        logic [LSU_ADDR_W-1:0] addr;
        logic [LSU_DATA_W-1:0] wdata;
        logic [LSU_STRB_W-1:0] wstrb;
    } word_req_t;

endpackage

/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

    //////////////////////////////////////////////////
    // memory bus sizes
    //////////////////////////////////////////////////

    localparam int MEM_ADDR_W     = 32;
    localparam int MEM_DATA_W     = 32;
    localparam int MEM_STRB_W     = MEM_DATA_W / 8;

    // 256 words of on-chip data ram
    localparam int RAM_DEPTH_LOG2 = 8;
    localparam int RAM_DEPTH      = 1 << RAM_DEPTH_LOG2;

    // address acceptance to data_ok, in cycles
    localparam int RAM_READ_LAT   = 2;
    localparam int LAT_CNT_W      = $clog2(RAM_READ_LAT + 1);

    //////////////////////////////////////////////////
    // request and response bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                  req;
        logic                  wr;
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_DATA_W-1:0] wdata;
        logic [MEM_STRB_W-1:0] wstrb;
    } mem_req_t;

    // addr_ok is the request accept, data_ok the read return
    typedef struct packed {
        logic                  addr_ok;
        logic                  data_ok;
        logic [MEM_DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator and run it, exit status follows the simulation

cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module tb_lsu_mem \
    -Mdir obj_dir -o tb_lsu_mem &&
./obj_dir/tb_lsu_mem ||
exit 1

/* sources.f */
design/mem_bus_pkg.sv
design/lsu_pkg.sv
design/lsu_align.sv
design/dcache_bypass.sv
design/data_ram.sv
design/lsu_mem_top.sv
verification/tb_lsu_mem.sv

/* verification/tb_lsu_mem.sv */
`timescale 1ns/1ps

module tb_lsu_mem;
    import lsu_pkg::*;
    import mem_bus_pkg::*;

    localparam int N_RAND    = 200;
    localparam int LOAD_LAT  = RAM_READ_LAT + 2;
    localparam int SHADOW_SZ = 1024;

    // one access per row
    typedef struct packed {
        lsu_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        mis;
    } row_t;

    logic        clk;
    logic        rstn;
    lsu_req_t    lsu_req;
    logic        ready;
    logic [31:0] rdata;
    logic        misalign;

    row_t        rows[$];
    // byte image of the ram, 256 words
    logic [7:0]  shadow [SHADOW_SZ];

    lsu_mem_top u_lsu_mem_top (
        .clk      (clk),
        .rstn     (rstn),
        .lsu_req  (lsu_req),
        .ready    (ready),
        .rdata    (rdata),
        .misalign (misalign)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic logic is_load(input lsu_op_e op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    function automatic logic [31:0] predict_load(input lsu_op_e op, input logic [31:0] addr);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        a = addr[9:0];
        b = shadow[a];
        // halfword starts on an even byte
        h = {shadow[a + 10'd1], shadow[a]};
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'd0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'd0, h};
            default: return {shadow[a + 10'd3], shadow[a + 10'd2], h};
        endcase
    endfunction

    // only the addressed bytes change
    function automatic void apply_store(input lsu_op_e op, input logic [31:0] addr,
                                        input logic [31:0] wdata);
        logic [9:0] a;
        a = addr[9:0];
        shadow[a] = wdata[7:0];
        if (op != OP_SB) begin
            shadow[a + 10'd1] = wdata[15:8];
        end
        if (op == OP_SW) begin
            shadow[a + 10'd2] = wdata[23:16];
            shadow[a + 10'd3] = wdata[31:24];
        end
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s got %08h expected %08h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic void add_row(input lsu_op_e op, input logic [31:0] addr,
                                    input logic [31:0] wdata, input logic mis);
        row_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        r.mis   = mis;
        rows.push_back(r);
    endfunction

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////

    task automatic build_table();
        // untouched words read zero, then a word round trip
        add_row(OP_LW, 32'h010, '0, 1'b0);
        add_row(OP_LW, 32'h3fc, '0, 1'b0);
        add_row(OP_SW, 32'h010, 32'h1234_5678, 1'b0);
        add_row(OP_LW, 32'h010, '0, 1'b0);
        // partial stores merge into one word
        add_row(OP_SW, 32'h020, 32'h1122_3344, 1'b0);
        add_row(OP_SB, 32'h021, 32'h0000_00a5, 1'b0);
        add_row(OP_SH, 32'h022, 32'h0000_beef, 1'b0);
        // upper data bits must not leak into other lanes
        add_row(OP_SB, 32'h027, 32'hffff_ff5a, 1'b0);
        add_row(OP_LW, 32'h020, '0, 1'b0);
        add_row(OP_LW, 32'h024, '0, 1'b0);
        // mixed sign bits in every lane
        add_row(OP_SW, 32'h030, 32'h80ff_7f81, 1'b0);
        for (int lane = 0; lane < 4; lane++) begin
            add_row(OP_LB, 32'h030 + lane, '0, 1'b0);
            add_row(OP_LBU, 32'h030 + lane, '0, 1'b0);
        end
        for (int half = 0; half < 2; half++) begin
            add_row(OP_LH, 32'h030 + 2 * half, '0, 1'b0);
            add_row(OP_LHU, 32'h030 + 2 * half, '0, 1'b0);
        end
        // rejected accesses, memory left alone
        add_row(OP_LH, 32'h031, '0, 1'b1);
        add_row(OP_SH, 32'h013, 32'hdead_beef, 1'b1);
        add_row(OP_SW, 32'h012, 32'hdead_beef, 1'b1);
        add_row(OP_LW, 32'h033, '0, 1'b1);
        add_row(OP_SW, 32'h011, 32'hcafe_f00d, 1'b1);
        add_row(OP_LW, 32'h010, '0, 1'b0);
        add_row(OP_LW, 32'h030, '0, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // one request, held until ready
    //////////////////////////////////////////////////

    task automatic do_access(input row_t r);
        lsu_req_t    req_v;
        int          cycles;
        logic [31:0] exp_data;
        req_v.valid = 1'b1;
        req_v.op    = r.op;
        req_v.addr  = r.addr;
        req_v.wdata = r.wdata;
        exp_data    = predict_load(r.op, r.addr);
        cycles      = 0;
        lsu_req <= req_v;
        // sample mid cycle, away from the driving edge
        @(negedge clk);
        while (!ready) begin
            cycles++;
            @(negedge clk);
        end
        check("misalign flag", 32'(misalign), 32'(r.mis));
        if (r.mis) begin
            check("misaligned completion cycle", cycles, 0);
        end else if (is_load(r.op)) begin
            check("load data", rdata, exp_data);
            check("load completion cycle", cycles, LOAD_LAT);
        end else begin
            check("store completion cycle", cycles, 0);
            apply_store(r.op, r.addr, r.wdata);
        end
    endtask

    initial begin : main
        row_t r;
        int   gap;
        clk        = 1'b0;
        rstn       = 1'b0;
        lsu_req    = '0;
        void'($urandom(32'h4a4d));
        for (int i = 0; i < SHADOW_SZ; i++) begin
            shadow[i] = 8'h00;
        end
        build_table();
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        foreach (rows[i]) begin
            do_access(rows[i]);
            @(posedge clk);
        end
        // random aligned traffic over 32 words
        for (int i = 0; i < N_RAND; i++) begin
            r.op   = lsu_op_e'(3'($urandom_range(0, 7)));
            r.addr = {24'd0, 8'($urandom_range(0, 127))};
            if (r.op inside {OP_LH, OP_LHU, OP_SH}) begin
                r.addr[0] = 1'b0;
            end else if (r.op inside {OP_LW, OP_SW}) begin
                r.addr[1:0] = 2'b00;
            end
            r.wdata = $urandom;
            r.mis   = 1'b0;
            gap     = $urandom_range(0, 3);
            do_access(r);
            @(posedge clk);
            if (gap != 0) begin
                lsu_req.valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

    // worst access plus gap stays under 10 cycles
    initial begin : watchdog
        @(posedge rstn);
        repeat ((rows.size() + N_RAND) * 10) @(posedge clk);
        $display("timeout, the DUT stopped completing accesses");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule
